// ==== logic/hbus_channel.sv ====
// hbus memory channel, line storage with lane-enable writes and a two-stage read pipeline
module hbus_channel (
    input  logic                            main_clock_i,
    input  logic                            main_reset_ni,

    // request from the router
    input  logic                            sel_i,
    input  logic                            write_i,
    input  logic [hbus_pkg::ROW_BITS-1:0]   row_i,
    input  logic [hbus_pkg::LANE_BITS-1:0]  lane_i,
    input  logic [hbus_pkg::WIDE_WIDTH-1:0] wdata_i,
    input  logic [hbus_pkg::NUM_LANES-1:0]  lane_en_i,

    // read response towards the merger
    output logic                            rsp_valid_o,
    output logic [hbus_pkg::WIDE_WIDTH-1:0] rsp_line_o,
    output logic [hbus_pkg::LANE_BITS-1:0]  rsp_lane_o
);

    import hbus_pkg::*;

    logic [WIDE_WIDTH-1:0] mem_q [CHANNEL_DEPTH];

    logic                  rd_valid_q; // first read stage
    logic [WIDE_WIDTH-1:0] rd_line_q;
    logic [LANE_BITS-1:0]  rd_lane_q;

    ////////////////////
    // line storage
    ////////////////////

    always_ff @(posedge main_clock_i) begin
        if (sel_i && write_i) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                if (lane_en_i[l]) begin
                    mem_q[row_i][l*NARROW_WIDTH +: NARROW_WIDTH] <=
                        wdata_i[l*NARROW_WIDTH +: NARROW_WIDTH];
                end
            end
        end
    end

    ////////////////////
    // read pipeline
    ////////////////////

    always_ff @(posedge main_clock_i or negedge main_reset_ni) begin
        if (!main_reset_ni) begin
            rd_valid_q  <= 1'b0;
            rsp_valid_o <= 1'b0;
        end else begin
            rd_valid_q  <= sel_i && !write_i;
            rsp_valid_o <= rd_valid_q;
        end
    end

    // array sampled in stage one, lane tag rides along
    always_ff @(posedge main_clock_i) begin
        if (sel_i && !write_i) begin
            rd_line_q <= mem_q[row_i];
            rd_lane_q <= lane_i;
        end
        if (rd_valid_q) begin
            rsp_line_o <= rd_line_q;
            rsp_lane_o <= rd_lane_q;
        end
    end

    // a write touches exactly one word of the line
    single_lane_write_a : assert property (
        @(posedge main_clock_i) disable iff (!main_reset_ni)
        (sel_i && write_i) |-> $onehot(lane_en_i)
    ) else $error("hbus channel: write with lane enables %b", lane_en_i);

endmodule : hbus_channel

// ==== logic/hbus_pkg.sv ====
// hbus package with the bus geometry, channel sizing and address layout of the memory subsystem
package hbus_pkg;

    ////////////////////
    // data widths
    ////////////////////

    localparam int NARROW_WIDTH = 32;  // processor side word
    localparam int WIDE_WIDTH   = 128; // one channel line
    localparam int NUM_LANES    = WIDE_WIDTH / NARROW_WIDTH;
    localparam int LANE_BITS    = $clog2(NUM_LANES);

    ////////////////////
    // channels
    ////////////////////

    localparam int NUM_CHANNELS  = 4;
    localparam int CHANNEL_BITS  = $clog2(NUM_CHANNELS);
    localparam int CHANNEL_DEPTH = 16; // lines per channel
    localparam int ROW_BITS      = $clog2(CHANNEL_DEPTH);

    // router, two channel stages, merger
    localparam int READ_LATENCY = 4;

    ////////////////////
    // address layout
    ////////////////////

    localparam int ADDR_WIDTH  = 32;
    localparam int OFFSET_BITS = $clog2(NARROW_WIDTH / 8); // byte within a word
    localparam int UNUSED_BITS = ADDR_WIDTH - ROW_BITS - CHANNEL_BITS - LANE_BITS
                                 - OFFSET_BITS;

    // Consecutive words fill the lanes of a line first, then move on to the
    // next channel, so a linear sweep touches every channel before reusing one.
    // Everything above the row is dropped and the space repeats every 1 KiB.
    typedef union packed {
        logic [ADDR_WIDTH-1:0] flat; // byte address as seen on the port
        struct packed {
            logic [UNUSED_BITS-1:0]  unused;  // aliased away
            logic [ROW_BITS-1:0]     row;
            logic [CHANNEL_BITS-1:0] channel;
            logic [LANE_BITS-1:0]    lane;    // word within the line
            logic [OFFSET_BITS-1:0]  offset;  // zero for word access
        } fields;
    } hbus_addr_u;

endpackage : hbus_pkg

// ==== logic/hbus_request_router.sv ====
// hbus request router, widens narrow requests into lines and strobes the addressed channel
module hbus_request_router (
    input  logic                              main_clock_i,
    input  logic                              main_reset_ni,

    // narrow request port
    input  logic                              req_valid_i,
    input  logic                              req_write_i,
    input  hbus_pkg::hbus_addr_u              req_addr_i,
    input  logic [hbus_pkg::NARROW_WIDTH-1:0] req_wdata_i,

    // broadcast to all channels, only the selected one acts
    output logic [hbus_pkg::NUM_CHANNELS-1:0] chan_sel_o,
    output logic                              chan_write_o,
    output logic [hbus_pkg::ROW_BITS-1:0]     chan_row_o,
    output logic [hbus_pkg::LANE_BITS-1:0]    chan_lane_o,
    output logic [hbus_pkg::WIDE_WIDTH-1:0]   chan_wdata_o,
    output logic [hbus_pkg::NUM_LANES-1:0]    chan_lane_en_o
);

    import hbus_pkg::*;

    logic [NUM_CHANNELS-1:0] chan_sel_d;
    logic [NUM_LANES-1:0]    lane_en_d;

    ////////////////////
    // address decode
    ////////////////////

    always_comb begin
        chan_sel_d = '0;
        if (req_valid_i) begin
            chan_sel_d[req_addr_i.fields.channel] = 1'b1;
        end
    end

    // one lane written, the others keep their contents
    always_comb begin
        lane_en_d = '0;
        lane_en_d[req_addr_i.fields.lane] = 1'b1;
    end

    ////////////////////
    // request register
    ////////////////////

    always_ff @(posedge main_clock_i or negedge main_reset_ni) begin
        if (!main_reset_ni) begin
            chan_sel_o <= '0;
        end else begin
            chan_sel_o <= chan_sel_d; // zero on idle cycles
        end
    end

    always_ff @(posedge main_clock_i) begin
        if (req_valid_i) begin
            chan_write_o   <= req_write_i;
            chan_row_o     <= req_addr_i.fields.row;
            chan_lane_o    <= req_addr_i.fields.lane; // read tag
            chan_wdata_o   <= {NUM_LANES{req_wdata_i}}; // word copied into every lane
            chan_lane_en_o <= lane_en_d;
        end
    end

    // only whole words travel on this port
    offset_aligned_a : assert property (
        @(posedge main_clock_i) disable iff (!main_reset_ni)
        req_valid_i |-> (req_addr_i.fields.offset == '0)
    ) else $error("hbus router: unaligned request address %h", req_addr_i.flat);

endmodule : hbus_request_router

// ==== logic/hbus_response_merge.sv ====
// hbus response merger, picks the answering channel and cuts the requested word from its line
module hbus_response_merge (
    input  logic                              main_clock_i,
    input  logic                              main_reset_ni,

    // one response slot per channel
    input  logic [hbus_pkg::NUM_CHANNELS-1:0] chan_valid_i,
    input  logic [hbus_pkg::NUM_CHANNELS-1:0][hbus_pkg::WIDE_WIDTH-1:0] chan_line_i,
    input  logic [hbus_pkg::NUM_CHANNELS-1:0][hbus_pkg::LANE_BITS-1:0]  chan_lane_i,

    // narrow read response
    output logic                              rsp_valid_o,
    output logic [hbus_pkg::NARROW_WIDTH-1:0] rsp_rdata_o
);

    import hbus_pkg::*;

    logic [WIDE_WIDTH-1:0]   sel_line;
    logic [LANE_BITS-1:0]    sel_lane;
    logic [NARROW_WIDTH-1:0] sel_word;

    // at most one channel answers per cycle, so a plain scan is enough
    always_comb begin
        sel_line = '0;
        sel_lane = '0;
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            if (chan_valid_i[c]) begin
                sel_line = chan_line_i[c];
                sel_lane = chan_lane_i[c];
            end
        end
    end

    assign sel_word = sel_line[sel_lane*NARROW_WIDTH +: NARROW_WIDTH]; // wide to narrow

    ////////////////////
    // output register
    ////////////////////

    always_ff @(posedge main_clock_i or negedge main_reset_ni) begin
        if (!main_reset_ni) begin
            rsp_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= |chan_valid_i;
        end
    end

    always_ff @(posedge main_clock_i) begin
        if (|chan_valid_i) begin
            rsp_rdata_o <= sel_word;
        end
    end

    // equal channel latency plus one request per cycle keeps responses apart
    single_responder_a : assert property (
        @(posedge main_clock_i) disable iff (!main_reset_ni)
        $onehot0(chan_valid_i)
    ) else $error("hbus merge: several channels responded at once (%b)", chan_valid_i);

endmodule : hbus_response_merge

// ==== logic/hbus_top.sv ====
// hbus top level, request router feeding interleaved memory channels and a response merger
module hbus_top (
    input  logic                              main_clock_i,
    input  logic                              main_reset_ni,

    // processor side request
    input  logic                              req_valid_i,
    input  logic                              req_write_i,
    input  logic [hbus_pkg::ADDR_WIDTH-1:0]   req_addr_i,
    input  logic [hbus_pkg::NARROW_WIDTH-1:0] req_wdata_i,

    // processor side read response
    output logic                              rsp_valid_o,
    output logic [hbus_pkg::NARROW_WIDTH-1:0] rsp_rdata_o
);

    import hbus_pkg::*;

    hbus_addr_u req_addr;

    logic [NUM_CHANNELS-1:0] chan_sel;
    logic                    chan_write;
    logic [ROW_BITS-1:0]     chan_row;
    logic [LANE_BITS-1:0]    chan_lane;
    logic [WIDE_WIDTH-1:0]   chan_wdata;
    logic [NUM_LANES-1:0]    chan_lane_en;

    logic [NUM_CHANNELS-1:0]                 chan_valid;
    logic [NUM_CHANNELS-1:0][WIDE_WIDTH-1:0] chan_line;
    logic [NUM_CHANNELS-1:0][LANE_BITS-1:0]  chan_lane_tag;

    assign req_addr.flat = req_addr_i; // field view decoded in the router

    hbus_request_router router_u (
        .main_clock_i   ( main_clock_i  ),
        .main_reset_ni  ( main_reset_ni ),
        .req_valid_i    ( req_valid_i   ),
        .req_write_i    ( req_write_i   ),
        .req_addr_i     ( req_addr      ),
        .req_wdata_i    ( req_wdata_i   ),
        .chan_sel_o     ( chan_sel      ),
        .chan_write_o   ( chan_write    ),
        .chan_row_o     ( chan_row      ),
        .chan_lane_o    ( chan_lane     ),
        .chan_wdata_o   ( chan_wdata    ),
        .chan_lane_en_o ( chan_lane_en  )
    );

    ////////////////////
    // memory channels
    ////////////////////

    for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_channel
        hbus_channel channel_u (
            .main_clock_i  ( main_clock_i     ),
            .main_reset_ni ( main_reset_ni    ),
            .sel_i         ( chan_sel[c]      ), // own strobe
            .write_i       ( chan_write       ),
            .row_i         ( chan_row         ),
            .lane_i        ( chan_lane        ),
            .wdata_i       ( chan_wdata       ),
            .lane_en_i     ( chan_lane_en     ),
            .rsp_valid_o   ( chan_valid[c]    ),
            .rsp_line_o    ( chan_line[c]     ),
            .rsp_lane_o    ( chan_lane_tag[c] )
        );
    end

    hbus_response_merge merge_u (
        .main_clock_i  ( main_clock_i  ),
        .main_reset_ni ( main_reset_ni ),
        .chan_valid_i  ( chan_valid    ),
        .chan_line_i   ( chan_line     ),
        .chan_lane_i   ( chan_lane_tag ),
        .rsp_valid_o   ( rsp_valid_o   ),
        .rsp_rdata_o   ( rsp_rdata_o   )
    );

endmodule : hbus_top

// ==== run.sh ====
#!/bin/sh
# build the hbus testbench with Verilator, run it and look for the pass line
verilator --binary --timing --assert -f tb.f --top-module tb_hbus_top -o sim_hbus \
    && ./obj_dir/sim_hbus | tee /dev/stderr | grep -q "TEST OK" \
    && echo "hbus simulation passed" \
    || { echo "hbus simulation failed"; exit 1; }

// ==== tb.f ====
+incdir+include
logic/hbus_pkg.sv
logic/hbus_request_router.sv
logic/hbus_channel.sv
logic/hbus_response_merge.sv
logic/hbus_top.sv
testbench/tb_hbus_top.sv

// ==== include/tb_lfsr.svh ====
// 16-bit Galois LFSR with a helper that draws random bits one step at a time
`ifndef TB_LFSR_SVH
`define TB_LFSR_SVH

// x^16 + x^14 + x^13 + x^11 + 1, maximal length
localparam logic [15:0] TB_LFSR_TAPS = 16'hB400;

function automatic logic [15:0] advance_lfsr(input logic [15:0] state);
    return {1'b0, state[15:1]} ^ (state[0] ? TB_LFSR_TAPS : 16'h0000);
endfunction

// one step per bit, msb drawn first
function automatic int unsigned draw_random_bits(inout logic [15:0] state, input int nbits);
    int unsigned value;
    value = 0;
    for (int i = 0; i < nbits; i++) begin
        state = advance_lfsr(state);
        value = (value << 1) | int'(state[0]);
    end
    return value;
endfunction

`endif

// ==== testbench/tb_hbus_top.sv ====
// testbench for the hbus memory subsystem with a reference word model and response checks
module tb_hbus_top;

    timeunit 1ns;
    timeprecision 1ps;

    import hbus_pkg::*;

    `include "tb_lfsr.svh"

    localparam int DRIVE_DELAY = 10;
    localparam int DRAIN_LIMIT = 3 * READ_LATENCY; // cycles to wait for the last response

    logic                    main_clock;
    logic                    main_reset_n;
    logic                    req_valid;
    logic                    req_write;
    logic [ADDR_WIDTH-1:0]   req_addr;
    logic [NARROW_WIDTH-1:0] req_wdata;
    logic                    rsp_valid;
    logic [NARROW_WIDTH-1:0] rsp_rdata;
    hbus_addr_u              req_fields;

    // reference model, one word per lane, channel and row
    logic [NARROW_WIDTH-1:0] model_mem [NUM_LANES][NUM_CHANNELS][CHANNEL_DEPTH];

    // outstanding reads in issue order, head mirrored for the checks
    logic [NARROW_WIDTH-1:0] exp_data_q [$];
    int                      exp_cycle_q [$]; // edge that accepted the read
    bit                      exp_pending = 1'b0;
    logic [NARROW_WIDTH-1:0] exp_data    = '0;
    int                      exp_cycle   = 0;
    int                      cycle_count = 0;

    string       test_name  = "reset";
    logic [15:0] lfsr_state = 16'd22;
    logic [31:0] written_addr_q [$]; // words the random phase may read back
    bit          known_word [256];

    hbus_top dut_i (
        .main_clock_i  ( main_clock   ),
        .main_reset_ni ( main_reset_n ),
        .req_valid_i   ( req_valid    ),
        .req_write_i   ( req_write    ),
        .req_addr_i    ( req_addr     ),
        .req_wdata_i   ( req_wdata    ),
        .rsp_valid_o   ( rsp_valid    ),
        .rsp_rdata_o   ( rsp_rdata    )
    );

    assign req_fields.flat = req_addr;

    initial begin
        main_clock = 1'b0;
        forever #50 main_clock = ~main_clock;
    end

    ////////////////////
    // model and monitor
    ////////////////////

    // sees each request on the edge that accepts it
    always @(posedge main_clock) begin
        cycle_count = cycle_count + 1;
        if (rsp_valid && exp_data_q.size() != 0) begin
            void'(exp_data_q.pop_front()); // head answered last cycle
            void'(exp_cycle_q.pop_front());
        end
        if (main_reset_n && req_valid) begin
            if (req_write) begin
                model_mem[req_fields.fields.lane][req_fields.fields.channel]
                         [req_fields.fields.row] = req_wdata;
            end else begin
                exp_data_q.push_back(model_mem[req_fields.fields.lane]
                                              [req_fields.fields.channel]
                                              [req_fields.fields.row]);
                exp_cycle_q.push_back(cycle_count);
            end
        end
        exp_pending = (exp_data_q.size() != 0);
        if (exp_pending) begin
            exp_data  = exp_data_q[0];
            exp_cycle = exp_cycle_q[0];
        end
    end

    task automatic stop_failed(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "hbus testbench stopped");
    endtask

    task automatic report_mismatch(input string what, input string expected,
                                   input string actual);
        stop_failed($sformatf("Mismatch in %s (%s): expected %s, actual %s",
                              test_name, what, expected, actual));
    endtask

    ////////////////////
    // response checks
    ////////////////////

    reset_quiet_a : assert property (
        @(negedge main_clock) !main_reset_n |-> !rsp_valid
    ) else stop_failed("read response raised while reset was applied");

    // writes and idle cycles stay silent
    no_stray_rsp_a : assert property (
        @(negedge main_clock) disable iff (!main_reset_n)
        rsp_valid |-> exp_pending
    ) else stop_failed($sformatf("response in %s without a read outstanding", test_name));

    // the coming rising edge is the one that samples the response
    rsp_latency_a : assert property (
        @(negedge main_clock) disable iff (!main_reset_n)
        (rsp_valid && exp_pending) |-> (cycle_count + 1 == exp_cycle + READ_LATENCY)
    ) else report_mismatch("response cycle", $sformatf("%0d", exp_cycle + READ_LATENCY),
                           $sformatf("%0d", cycle_count + 1));

    rsp_data_a : assert property (
        @(negedge main_clock) disable iff (!main_reset_n)
        (rsp_valid && exp_pending) |-> (rsp_rdata == exp_data)
    ) else report_mismatch("read data", $sformatf("%h", exp_data),
                           $sformatf("%h", rsp_rdata));

    rsp_missing_a : assert property (
        @(negedge main_clock) disable iff (!main_reset_n)
        exp_pending |-> (cycle_count + 1 <= exp_cycle + READ_LATENCY)
    ) else stop_failed($sformatf("read response missing in %s", test_name));

    ////////////////////
    // stimulus
    ////////////////////

    task automatic next_cycle();
        @(posedge main_clock);
        #DRIVE_DELAY;
    endtask

    task automatic drive_request(input logic write, input logic [31:0] addr,
                                 input logic [31:0] data);
        req_valid = 1'b1;
        req_write = write;
        req_addr  = addr;
        req_wdata = data;
        next_cycle();
        req_valid = 1'b0; // back to back calls keep it high at the edge
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
        drive_request(1'b1, addr, data);
    endtask

    task automatic read_word(input logic [31:0] addr);
        drive_request(1'b0, addr, '0);
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (exp_data_q.size() != 0) begin
            if (waited == DRAIN_LIMIT) begin
                stop_failed($sformatf("timeout in %s waiting for read responses", test_name));
            end else begin
                next_cycle();
                waited++;
            end
        end
    endtask

    initial begin
        logic [31:0] addr;
        logic [7:0]  word;
        int          pick;
        req_valid    = 1'b0;
        req_write    = 1'b0;
        req_addr     = '0;
        req_wdata    = '0;
        main_reset_n = 1'b0;
        repeat (2) @(posedge main_clock);
        #DRIVE_DELAY;
        main_reset_n = 1'b1;
        repeat (4) next_cycle(); // idle after reset

        test_name = "write_then_read"; // ch 2, lane 1, row 5
        write_word(32'h0000_0164, 32'hCAFE_0001);
        read_word(32'h0000_0164);
        wait_drained();
        write_word(32'h0000_0164, 32'hCAFE_0002);
        repeat (6) next_cycle(); // a lone write stays unanswered
        read_word(32'h0000_0164);
        wait_drained();

        test_name = "lane_isolation"; // ch 1, row 9
        for (int l = 0; l < NUM_LANES; l++) begin
            write_word(32'(592 + 4 * l), 32'hA000_0000 + 32'(l));
        end
        for (int l = 0; l < NUM_LANES; l++) begin
            read_word(32'(592 + 4 * l));
        end
        wait_drained();

        test_name = "interleave"; // row 3, lane 2, every channel
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            write_word(32'(200 + 16 * c), 32'h5C00_0000 + 32'(c));
        end
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            read_word(32'(200 + 16 * c));
        end
        wait_drained();

        test_name = "random_mix";
        for (int n = 0; n < 200; n++) begin
            if (written_addr_q.size() == 0 || draw_random_bits(lfsr_state, 1) == 1) begin
                word = 8'(draw_random_bits(lfsr_state, 8));
                addr = {22'b0, word, 2'b00}; // word aligned, low 1 KiB
                write_word(addr, draw_random_bits(lfsr_state, 32));
                if (!known_word[word]) begin
                    known_word[word] = 1'b1;
                    written_addr_q.push_back(addr);
                end
            end else begin
                pick = int'(draw_random_bits(lfsr_state, 8) % written_addr_q.size());
                read_word(written_addr_q[pick]);
            end
            if (draw_random_bits(lfsr_state, 2) == 0) begin
                next_cycle(); // occasional idle slot
            end
        end
        wait_drained();

        test_name = "idle_end";
        repeat (4) next_cycle();
        $display("TEST OK");
        $finish;
    end

endmodule : tb_hbus_top
